// File: common/noc_shim_pkg.sv
package noc_shim_pkg;

    // Stream side
    localparam int TDATA_W    = 64;
    localparam int DEST_W     = 3;

    // Each stream word is carried as this many flits
    localparam int SER_FACTOR = 4;
    localparam int FLIT_W     = TDATA_W / SER_FACTOR;

    // Credits the far side grants us after reset
    localparam int FLIT_CREDITS = 4;

    // Buffer depths in flits
    localparam int TX_DEPTH = 4;
    localparam int RX_DEPTH = 4 * SER_FACTOR;

    // Wide enough to hold RX_DEPTH itself
    localparam int CREDIT_W = $clog2(RX_DEPTH) + 1;

    typedef struct packed {
        logic [TDATA_W-1:0] data;
        logic [DEST_W-1:0]  dest;
        logic               last;
    } axis_word_t;

    // Tail marks the final flit of a packet, not of every word
    typedef struct packed {
        logic [FLIT_W-1:0] data;
        logic [DEST_W-1:0] dest;
        logic              tail;
    } flit_t;

endpackage

// File: serdes/axis_serializer.sv
`timescale 1ns/1ps

module axis_serializer import noc_shim_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    output logic       in_ready,
    input  axis_word_t in_word,

    output logic       out_valid,
    input  logic       out_ready,
    output flit_t      out_flit
);

    axis_word_t                    word_q;
    logic [$clog2(SER_FACTOR)-1:0] ser_cnt;
    logic                          last_slice;
    logic                          flit_done;

    assign last_slice = (ser_cnt == SER_FACTOR - 1);
    assign flit_done  = out_valid && out_ready;

    // Take the next word as the final flit of this one goes out
    assign in_ready = !out_valid || (flit_done && last_slice);

    assign out_flit.data = word_q.data[ser_cnt * FLIT_W +: FLIT_W];
    assign out_flit.dest = word_q.dest;
    assign out_flit.tail = word_q.last && last_slice;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ser_cnt <= '0;
        end else if (flit_done) begin
            if (last_slice) begin
                ser_cnt <= '0;
            end else begin
                ser_cnt <= ser_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (flit_done && last_slice) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            word_q <= in_word;
        end
    end

endmodule

// File: serdes/axis_deserializer.sv
`timescale 1ns/1ps

module axis_deserializer import noc_shim_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       in_valid,
    output logic       in_ready,
    input  flit_t      in_flit,
    output logic       pop,

    output logic       out_valid,
    input  logic       out_ready,
    output axis_word_t out_word
);

    axis_word_t                    word_q;
    logic [$clog2(SER_FACTOR)-1:0] ser_cnt;
    logic                          last_slice;

    assign last_slice = (ser_cnt == SER_FACTOR - 1);

    // No flits are taken while a finished word waits downstream
    assign in_ready = !out_valid;
    assign pop      = in_valid && in_ready;
    assign out_word = word_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ser_cnt <= '0;
        end else if (pop) begin
            if (last_slice) begin
                ser_cnt <= '0;
            end else begin
                ser_cnt <= ser_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (pop && last_slice) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            word_q.data[ser_cnt * FLIT_W +: FLIT_W] <= in_flit.data;
            // Dest and last come from the final flit
            if (last_slice) begin
                word_q.dest <= in_flit.dest;
                word_q.last <= in_flit.tail;
            end
        end
    end

endmodule

// File: src/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo import noc_shim_pkg::*; #(
    parameter int DEPTH     = 4,
    parameter int COUNT_W   = 3,
    parameter bit SHOWAHEAD = 1'b0
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               wr,
    input  flit_t              wr_flit,
    output logic               full,

    input  logic               rd,
    output flit_t              rd_flit,
    output logic               empty,
    output logic [COUNT_W-1:0] count
);

    // DEPTH is a power of two so the pointers wrap on their own
    flit_t              mem [DEPTH];
    logic [COUNT_W-2:0] wr_ptr;
    logic [COUNT_W-2:0] rd_ptr;

    assign full  = (count == COUNT_W'(DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr && !rd) begin
                count <= count + 1'b1;
            end else if (!wr && rd) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    generate
        if (SHOWAHEAD) begin : g_showahead
            assign rd_flit = mem[rd_ptr];
        end else begin : g_registered
            always_ff @(posedge clk) begin
                if (rd) begin
                    rd_flit <= mem[rd_ptr];
                end
            end
        end
    endgenerate

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);

endmodule

// File: src/link_credit_ctrl.sv
`timescale 1ns/1ps

module link_credit_ctrl import noc_shim_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                tx_empty,
    output logic                tx_rd,
    output logic                send_out,
    input  logic                credit_in,

    input  logic                send_in,
    input  logic [CREDIT_W-1:0] rx_count,
    input  logic                rx_pop,
    output logic                credit_out
);

    // Credits we may still spend on the link
    logic [CREDIT_W-1:0] tx_credits;
    // Credits the far side currently holds against our receive buffer
    logic [CREDIT_W-1:0] rx_credits;
    logic [CREDIT_W-1:0] rx_free;

    assign tx_rd = (tx_credits != '0) && !tx_empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_credits <= CREDIT_W'(FLIT_CREDITS);
        end else begin
            if (credit_in && !tx_rd) begin
                tx_credits <= tx_credits + 1'b1;
            end else if (!credit_in && tx_rd) begin
                tx_credits <= tx_credits - 1'b1;
            end
        end
    end

    // Flit leaves the buffer register one cycle after the read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            send_out <= 1'b0;
        end else begin
            send_out <= tx_rd;
        end
    end

    assign rx_free = CREDIT_W'(RX_DEPTH) - rx_count;

    // Return a credit only while the buffer can absorb everything granted
    // A pop this cycle frees the slot that the new credit would claim
    assign credit_out = ((rx_credits < CREDIT_W'(FLIT_CREDITS)) || send_in) &&
                        ((rx_credits < rx_free) || rx_pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_credits <= CREDIT_W'(FLIT_CREDITS);
        end else begin
            if (credit_out && !send_in) begin
                rx_credits <= rx_credits + 1'b1;
            end else if (!credit_out && send_in) begin
                rx_credits <= rx_credits - 1'b1;
            end
        end
    end

    // Far side must never hand back more than it was granted
    a_tx_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        tx_credits <= CREDIT_W'(FLIT_CREDITS)
    );

    a_rx_send_has_credit: assert property (
        @(posedge clk) disable iff (!rst_n)
        send_in |-> (rx_credits != '0)
    );

endmodule

// File: src/noc_axis_shim.sv
`timescale 1ns/1ps

module noc_axis_shim import noc_shim_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       s_valid,
    output logic       s_ready,
    input  axis_word_t s_word,

    output logic       m_valid,
    input  logic       m_ready,
    output axis_word_t m_word,

    output flit_t      flit_out,
    output logic       send_out,
    input  logic       credit_in,

    input  flit_t      flit_in,
    input  logic       send_in,
    output logic       credit_out
);

    logic                ser_valid;
    logic                ser_ready;
    flit_t               ser_flit;
    logic                tx_wr;
    logic                tx_full;
    logic                tx_empty;
    logic                tx_rd;

    flit_t               rx_flit;
    logic                rx_empty;
    logic                rx_valid;
    logic                rx_pop;
    logic [CREDIT_W-1:0] rx_count;

    assign ser_ready = !tx_full;
    assign tx_wr     = ser_valid && ser_ready;
    assign rx_valid  = !rx_empty;

    axis_serializer u_ser (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (s_valid),
        .in_ready  (s_ready),
        .in_word   (s_word),
        .out_valid (ser_valid),
        .out_ready (ser_ready),
        .out_flit  (ser_flit)
    );

    // Registered read port, so flit_out lines up with send_out
    flit_fifo #(
        .DEPTH     (TX_DEPTH),
        .COUNT_W   ($clog2(TX_DEPTH) + 1),
        .SHOWAHEAD (1'b0)
    ) tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (tx_wr),
        .wr_flit (ser_flit),
        .full    (tx_full),
        .rd      (tx_rd),
        .rd_flit (flit_out),
        .empty   (tx_empty),
        .count   ()
    );

    link_credit_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_empty   (tx_empty),
        .tx_rd      (tx_rd),
        .send_out   (send_out),
        .credit_in  (credit_in),
        .send_in    (send_in),
        .rx_count   (rx_count),
        .rx_pop     (rx_pop),
        .credit_out (credit_out)
    );

    flit_fifo #(
        .DEPTH     (RX_DEPTH),
        .COUNT_W   (CREDIT_W),
        .SHOWAHEAD (1'b1)
    ) rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (send_in),
        .wr_flit (flit_in),
        .full    (),
        .rd      (rx_pop),
        .rd_flit (rx_flit),
        .empty   (rx_empty),
        .count   (rx_count)
    );

    axis_deserializer u_deser (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (rx_valid),
        .in_ready  (),
        .in_flit   (rx_flit),
        .pop       (rx_pop),
        .out_valid (m_valid),
        .out_ready (m_ready),
        .out_word  (m_word)
    );

endmodule

// File: dv/noc_shim_tb_util.svh
`ifndef NOC_SHIM_TB_UTIL_SVH
`define NOC_SHIM_TB_UTIL_SVH

// 32-bit xorshift on rng_state of the including module
function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// Slice k of a stream word counted from the low end
function automatic logic [FLIT_W-1:0] ref_slice(
    input logic [TDATA_W-1:0] data,
    input int                 k
);
    logic [TDATA_W-1:0] shifted;
    shifted = data >> (k * FLIT_W);
    return shifted[FLIT_W-1:0];
endfunction

// Flit k of a word as it should appear on the link
function automatic flit_t ref_flit(
    input axis_word_t word,
    input int         k
);
    flit_t f;
    f.data = ref_slice(word.data, k);
    f.dest = word.dest;
    f.tail = word.last && (k == SER_FACTOR - 1);
    return f;
endfunction

task automatic check_value(
    input string       name,
    input logic [63:0] got,
    input logic [63:0] expected
);
    if (got !== expected) begin
        report_failure($sformatf("MISMATCH at %0t: %s got %h, expected %h",
                                 $time, name, got, expected));
    end
endtask

`endif

// File: dv/noc_axis_shim_tb.sv
`timescale 1ns/1ps

module noc_axis_shim_tb import noc_shim_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n;
    logic        s_valid;
    logic        s_ready;
    axis_word_t  s_word;
    logic        m_valid;
    logic        m_ready;
    axis_word_t  m_word;
    flit_t       flit_out;
    logic        send_out;
    logic        credit_in;
    flit_t       flit_in;
    logic        send_in;
    logic        credit_out;

    logic [31:0] rng_state = 32'h4096fa34;
    axis_word_t  exp_words[$];
    flit_t       exp_flits[$];
    int          credit_due[$];
    int          words_sent;
    int          words_received;
    int          src_limit;
    logic        hold_ready;
    int          in_flight;
    int          link_cycle;

    `include "noc_shim_tb_util.svh"

    noc_axis_shim dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .s_word     (s_word),
        .m_valid    (m_valid),
        .m_ready    (m_ready),
        .m_word     (m_word),
        .flit_out   (flit_out),
        .send_out   (send_out),
        .credit_in  (credit_in),
        .flit_in    (flit_in),
        .send_in    (send_in),
        .credit_out (credit_out)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    function automatic axis_word_t random_word();
        axis_word_t w;
        w.data[63:32] = next_rand();
        w.data[31:0]  = next_rand();
        w.dest        = DEST_W'(next_rand());
        w.last        = (next_rand() % 4) == 0;
        return w;
    endfunction

    task automatic check_reset_state();
        check_value("send_out", 64'(send_out), 64'(1'b0));
        check_value("credit_out", 64'(credit_out), 64'(1'b0));
        check_value("m_valid", 64'(m_valid), 64'(1'b0));
        check_value("s_ready", 64'(s_ready), 64'(1'b1));
    endtask

    task automatic wait_for_words(input int target, input int limit);
        int n;
        n = 0;
        while (words_received < target) begin
            @(posedge clk);
            n = n + 1;
            if (n > limit) begin
                report_failure($sformatf("timed out waiting for %0d words, %0d arrived",
                                         target, words_received));
            end
        end
    endtask

    task automatic wait_for_credits(input int limit);
        int n;
        n = 0;
        while (in_flight != 0) begin
            @(posedge clk);
            n = n + 1;
            if (n > limit) begin
                report_failure("timed out waiting for all link credits to come back");
            end
        end
    endtask

    // Source keeps a word stable until it is taken
    always @(posedge clk) begin : source
        int sent;
        sent = words_sent;
        if (s_valid && s_ready) begin
            exp_words.push_back(s_word);
            for (int k = 0; k < SER_FACTOR; k++) begin
                exp_flits.push_back(ref_flit(s_word, k));
            end
            sent = sent + 1;
            words_sent <= sent;
        end
        if (!s_valid || s_ready) begin
            if (rst_n && sent < src_limit && (next_rand() % 4) != 0) begin
                s_valid <= 1'b1;
                s_word  <= random_word();
            end else begin
                s_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : sink
        if (hold_ready) begin
            m_ready <= 1'b0;
        end else begin
            m_ready <= (next_rand() % 3) != 0;
        end
    end

    // Loopback link with a random credit return delay of 0 to 5 cycles
    always @(posedge clk) begin : link_model
        int outstanding;
        int due;
        link_cycle = link_cycle + 1;
        if (!rst_n) begin
            send_in   <= 1'b0;
            credit_in <= 1'b0;
        end else begin
            outstanding = in_flight + int'(send_out) - int'(credit_in);
            if (outstanding > FLIT_CREDITS) begin
                report_failure("more flits on the link than credits granted");
            end
            if (outstanding < 0) begin
                report_failure("credit returned for a flit that was never sent");
            end
            in_flight <= outstanding;
            send_in   <= send_out;
            flit_in   <= flit_out;
            if (credit_out) begin
                due = link_cycle + int'(next_rand() % 6);
                if (credit_due.size() != 0 && due <= credit_due[$]) begin
                    due = credit_due[$] + 1;
                end
                credit_due.push_back(due);
            end
            if (credit_due.size() != 0 && credit_due[0] <= link_cycle) begin
                void'(credit_due.pop_front());
                credit_in <= 1'b1;
            end else begin
                credit_in <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : flit_check
        flit_t ef;
        if (rst_n && send_out) begin
            if (exp_flits.size() == 0) begin
                report_failure("send_out strobe with no flit expected");
            end
            ef = exp_flits.pop_front();
            check_value("flit_out.data", 64'(flit_out.data), 64'(ef.data));
            check_value("flit_out.dest", 64'(flit_out.dest), 64'(ef.dest));
            check_value("flit_out.tail", 64'(flit_out.tail), 64'(ef.tail));
        end
    end

    always @(posedge clk) begin : word_check
        axis_word_t ew;
        if (rst_n && m_valid && m_ready) begin
            if (exp_words.size() == 0) begin
                report_failure("m_word handshake with no word expected");
            end
            ew = exp_words.pop_front();
            check_value("m_word.data", 64'(m_word.data), 64'(ew.data));
            check_value("m_word.dest", 64'(m_word.dest), 64'(ew.dest));
            check_value("m_word.last", 64'(m_word.last), 64'(ew.last));
            words_received <= words_received + 1;
        end
    end

    initial begin
        logic stalled;
        rst_n      = 1'b0;
        s_valid    = 1'b0;
        s_word     = '0;
        m_ready    = 1'b0;
        flit_in    = '0;
        send_in    = 1'b0;
        credit_in  = 1'b0;
        hold_ready = 1'b0;
        src_limit  = 0;

        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_reset_state();
            end
        end
        rst_n <= 1'b1;
        @(posedge clk);
        check_reset_state();

        src_limit <= 200;
        wait_for_words(200, 20000);

        // Stall the output and keep offering words
        hold_ready <= 1'b1;
        src_limit  <= 240;
        stalled = 1'b1;
        for (int i = 0; i < 100; i++) begin
            @(posedge clk);
            // The stall has reached the source well before the last 20 cycles
            if (i >= 80 && s_ready) begin
                stalled = 1'b0;
            end
        end
        if (!stalled) begin
            report_failure("s_ready did not stay low while m_ready was held low");
        end
        hold_ready <= 1'b0;
        wait_for_words(240, 5000);
        wait_for_credits(50);

        if (exp_flits.size() != 0 || exp_words.size() != 0) begin
            report_failure("expected flits or words left over at the end");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: noc_axis_shim.f
+incdir+dv
common/noc_shim_pkg.sv
serdes/axis_serializer.sv
serdes/axis_deserializer.sv
src/flit_fifo.sv
src/link_credit_ctrl.sv
src/noc_axis_shim.sv
dv/noc_axis_shim_tb.sv
